// ==== flist.f ====
+incdir+hdl
hdl/cgraIsaPkg.sv
hdl/cgraCtrlPkg.sv
hdl/tileConfigMem.sv
hdl/tileAlu.sv
hdl/cgraTile.sv
hdl/cgra.sv
verification/cgra_asserts.sv
verification/cgraTb.sv

// ==== verification/cgraTb.sv ====
/*
 * directed testbench for the CGRA torus
 * loads tile programs over the cfg port, runs them, checks stores and end flags
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module cgraTb;

   import cgraIsaPkg::*;

   localparam int waitLimit = 200;   // cycles per wait loop

   logic                                    clk;
   logic                                    arstN;
   logic                                    cfgWrEn;
   logic [`CGRA_CFG_AW-1:0]                 cfgAddr;
   logic [`CGRA_DW-1:0]                     cfgData;
   logic                                    execEn;
   logic [`CGRA_NTILES-1:0]                 storeGrant;
   logic [`CGRA_NTILES-1:0]                 storeReq;
   logic [`CGRA_NTILES-1:0][`CGRA_DW-1:0]   storeAddr;
   logic [`CGRA_NTILES-1:0][`CGRA_DW-1:0]   storeData;
   logic [`CGRA_NTILES-1:0]                 endExec;

   int          errCount;
   int          checkCount;
   int          timeoutCount;
   logic [31:0] lfsrState;

   cgra DUT (
      .clk        (clk),
      .arstN      (arstN),
      .cfgWrEn    (cfgWrEn),
      .cfgAddr    (cfgAddr),
      .cfgData    (cfgData),
      .execEn     (execEn),
      .storeGrant (storeGrant),
      .storeReq   (storeReq),
      .storeAddr  (storeAddr),
      .storeData  (storeData),
      .endExec    (endExec)
   );

   always #50 clk = ~clk;   // 100 ns period

   ///////////////////////////////
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = {lfsrState[30:0],
                      lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
         v = {v[30:0], lfsrState[0]};   // one step per bit
      end
      return v;
   endfunction

   ///////////////////////////////
   // drive helpers
   task automatic stepCycle();
      @(posedge clk);
      #10;   // drive and sample point
   endtask

   task automatic applyReset();
      arstN      = 1'b0;
      execEn     = 1'b0;
      cfgWrEn    = 1'b0;
      storeGrant = '1;
      repeat (3) @(posedge clk);
      #10;
      arstN = 1'b1;
   endtask

   // encode one instruction from the field layout and write it to {tile, slot}
   task automatic writeInstr(input int tile, input int slot, input cgraOpT op,
                             input int dst, input cgraSrcT a, input cgraSrcT b,
                             input logic [15:0] imm);
      logic [31:0] w;
      w = '0;
      w[`CGRA_OP_HI:`CGRA_OP_LO]     = op;
      w[`CGRA_DST_HI:`CGRA_DST_LO]   = 2'(dst);
      w[`CGRA_SRCA_HI:`CGRA_SRCA_LO] = a;
      w[`CGRA_SRCB_HI:`CGRA_SRCB_LO] = b;
      w[`CGRA_IMM_HI:`CGRA_IMM_LO]   = imm;
      cfgWrEn = 1'b1;
      cfgAddr = `CGRA_CFG_AW'(tile * `CGRA_PROG_DEPTH + slot);
      cfgData = w;
      stepCycle();
      cfgWrEn = 1'b0;
   endtask

   task automatic checkEq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errCount++;
         $display("CHECK FAILED at %0d ns: %s expected 0x%08h, got 0x%08h",
                  $time, name, expected, actual);
      end
   endtask

   ///////////////////////////////
   // bounded waits
   task automatic waitStore(input int tile, output bit found);
      int cnt;
      cnt = 0;
      while (!storeReq[tile] && cnt < waitLimit) begin
         stepCycle();
         cnt++;
      end
      found = storeReq[tile];
      if (!found) begin
         timeoutCount++;
         $display("timeout: tile %0d made no store request within %0d cycles", tile, waitLimit);
      end
   endtask

   task automatic waitEnd(input int tile);
      int cnt;
      cnt = 0;
      while (!endExec[tile] && cnt < waitLimit) begin
         stepCycle();
         cnt++;
      end
      if (!endExec[tile]) begin
         timeoutCount++;
         $display("timeout: tile %0d never raised endExec within %0d cycles", tile, waitLimit);
      end
   endtask

   task automatic waitEndLow(input int tile);
      int cnt;
      cnt = 0;
      while (endExec[tile] && cnt < waitLimit) begin
         stepCycle();
         cnt++;
      end
      if (endExec[tile]) begin
         timeoutCount++;
         $display("timeout: tile %0d kept endExec high after execEn fell", tile);
      end
   endtask

   ///////////////////////////////
   // tests
   task automatic checkIdleAfterReset();
      applyReset();
      checkEq("endExec after reset", '0, endExec);
      checkEq("storeReq after reset", '0, storeReq);
      execEn = 1'b1;   // nothing loaded so every slot is a NOP
      repeat (20) begin
         stepCycle();
         checkEq("storeReq, empty array", '0, storeReq);
         checkEq("endExec, empty array", '0, endExec);
      end
   endtask

   task automatic exerciseAluStores();
      cgraOpT      ops [4];
      logic [15:0] a;
      logic [15:0] b;
      logic [31:0] expected;
      bit          found;
      ops = '{opSub, opAdd, opAnd, opXor};
      foreach (ops[i]) begin
         a = 16'(randBits(16));
         b = 16'(randBits(16));
         case (ops[i])
            opSub:   expected = {16'h0, a} - {16'h0, b};   // wraps mod 2^32
            opAdd:   expected = {16'h0, a} + {16'h0, b};
            opAnd:   expected = {16'h0, a & b};
            default: expected = {16'h0, a ^ b};
         endcase
         applyReset();
         writeInstr(0, 0, opMovi, 0, srcR0, srcR0, a);
         writeInstr(0, 1, opMovi, 1, srcR0, srcR0, b);
         writeInstr(0, 2, ops[i], 2, srcR0, srcR1, 16'h0);
         writeInstr(0, 3, opStore, 0, srcR2, srcR0, 16'd4);
         writeInstr(0, 4, opHalt, 0, srcR0, srcR0, 16'h0);
         execEn = 1'b1;
         waitStore(0, found);
         if (found) begin
            checkEq("storeAddr[0]", 32'd4, storeAddr[0]);
            checkEq($sformatf("storeData[0] for %s", ops[i].name()), expected, storeData[0]);
            stepCycle();
            checkEq("storeReq[0] after grant", 1'b0, storeReq[0]);   // single store
         end
         waitEnd(0);
      end
   endtask

   // tile 1 sums W and E and tile 2 sums N and S, all four wrap onto tile 0
   task automatic torusNeighbourSum();
      int          targets [2];
      cgraSrcT     srcA;
      cgraSrcT     srcB;
      logic [15:0] v;
      bit          found;
      targets = '{1, 2};
      foreach (targets[k]) begin
         if (targets[k] == 1) begin
            srcA = srcW;
            srcB = srcE;
         end else begin
            srcA = srcN;
            srcB = srcS;
         end
         v = 16'(randBits(16));
         applyReset();
         writeInstr(0, 0, opMovi, 0, srcR0, srcR0, v);
         for (int s = 1; s < 4; s++) begin
            writeInstr(0, s, opNop, 0, srcR0, srcR0, 16'h0);
         end
         writeInstr(0, 4, opHalt, 0, srcR0, srcR0, 16'h0);
         writeInstr(targets[k], 0, opNop, 0, srcR0, srcR0, 16'h0);
         writeInstr(targets[k], 1, opNop, 0, srcR0, srcR0, 16'h0);
         writeInstr(targets[k], 2, opAdd, 0, srcA, srcB, 16'h0);
         writeInstr(targets[k], 3, opStore, 0, srcR0, srcR0, 16'd8);
         writeInstr(targets[k], 4, opHalt, 0, srcR0, srcR0, 16'h0);
         execEn = 1'b1;
         waitStore(targets[k], found);
         if (found) begin
            checkEq($sformatf("storeAddr[%0d]", targets[k]), 32'd8, storeAddr[targets[k]]);
            checkEq($sformatf("storeData[%0d]", targets[k]), {16'h0, v} + {16'h0, v},
                    storeData[targets[k]]);
         end
         waitEnd(targets[k]);
         waitEnd(0);
      end
   endtask

   task automatic stalledStoreGrant();
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      logic [15:0] d;
      logic [31:0] heldAddr;
      logic [31:0] heldData;
      int          stallLen;
      bit          found;
      a        = 16'(randBits(16));
      b        = 16'(randBits(16));
      c        = 16'(randBits(16));
      d        = 16'(randBits(16));
      stallLen = 3 + int'(randBits(3));   // 3 to 10 cycles
      applyReset();
      storeGrant[0] = 1'b0;   // tile 0 store has to wait
      writeInstr(0, 0, opMovi, 0, srcR0, srcR0, a);
      writeInstr(0, 1, opMovi, 1, srcR0, srcR0, b);
      writeInstr(0, 2, opAdd, 2, srcR0, srcR1, 16'h0);
      writeInstr(0, 3, opStore, 0, srcR2, srcR0, 16'd12);
      writeInstr(0, 4, opHalt, 0, srcR0, srcR0, 16'h0);
      // longer program still mid-run when tile 0 blocks
      writeInstr(1, 0, opMovi, 0, srcR0, srcR0, c);
      writeInstr(1, 1, opMovi, 1, srcR0, srcR0, d);
      writeInstr(1, 2, opXor, 3, srcR0, srcR1, 16'h0);
      writeInstr(1, 3, opNop, 0, srcR0, srcR0, 16'h0);
      writeInstr(1, 4, opNop, 0, srcR0, srcR0, 16'h0);
      writeInstr(1, 5, opStore, 0, srcR3, srcR0, 16'd16);
      writeInstr(1, 6, opHalt, 0, srcR0, srcR0, 16'h0);
      execEn = 1'b1;
      waitStore(0, found);
      if (found) begin
         heldAddr = storeAddr[0];
         heldData = storeData[0];
         checkEq("storeAddr[0]", 32'd12, heldAddr);
         checkEq("storeData[0]", {16'h0, a} + {16'h0, b}, heldData);
         repeat (stallLen) begin
            checkEq("storeReq[0] while stalled", 1'b1, storeReq[0]);
            checkEq("storeAddr[0] while stalled", heldAddr, storeAddr[0]);
            checkEq("storeData[0] while stalled", heldData, storeData[0]);
            checkEq("storeReq[1] while stalled", 1'b0, storeReq[1]);   // tile 1 frozen too
            checkEq("endExec[1] while stalled", 1'b0, endExec[1]);
            stepCycle();
         end
         storeGrant[0] = 1'b1;
         stepCycle();
         checkEq("storeReq[0] after grant", 1'b0, storeReq[0]);
      end
      waitStore(1, found);
      if (found) begin
         checkEq("storeAddr[1]", 32'd16, storeAddr[1]);
         checkEq("storeData[1]", {16'h0, c ^ d}, storeData[1]);
      end
      waitEnd(0);
      waitEnd(1);
   endtask

   // second pass rewrites only the immediates while execEn is low
   task automatic reprogramAndRerun();
      logic [15:0] p;
      logic [15:0] q;
      bit          found;
      applyReset();
      for (int pass = 0; pass < 2; pass++) begin
         p = 16'(randBits(16));
         q = 16'(randBits(16));
         writeInstr(3, 0, opMovi, 1, srcR0, srcR0, p);
         writeInstr(3, 1, opMovi, 3, srcR0, srcR0, q);
         if (pass == 0) begin
            writeInstr(3, 2, opSub, 0, srcR1, srcR3, 16'h0);
            writeInstr(3, 3, opStore, 0, srcR0, srcR0, 16'd20);
            writeInstr(3, 4, opHalt, 0, srcR0, srcR0, 16'h0);
         end
         execEn = 1'b1;
         waitStore(3, found);
         if (found) begin
            checkEq($sformatf("storeAddr[3] pass %0d", pass), 32'd20, storeAddr[3]);
            checkEq($sformatf("storeData[3] pass %0d", pass), {16'h0, p} - {16'h0, q},
                    storeData[3]);
         end
         waitEnd(3);
         execEn = 1'b0;   // back through idle
         waitEndLow(3);
      end
   endtask

   ///////////////////////////////
   // main sequence
   initial begin
      clk          = 1'b0;
      arstN        = 1'b0;
      cfgWrEn      = 1'b0;
      cfgAddr      = '0;
      cfgData      = '0;
      execEn       = 1'b0;
      storeGrant   = '1;
      errCount     = 0;
      checkCount   = 0;
      timeoutCount = 0;
      lfsrState    = 32'he740;
      checkIdleAfterReset();
      exerciseAluStores();
      torusNeighbourSum();
      stalledStoreGrant();
      reprogramAndRerun();
      $display("cgraTb done: %0d checks, %0d mismatches, %0d timeouts",
               checkCount, errCount, timeoutCount);
      if (errCount == 0 && timeoutCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/cgra_asserts.sv ====
/*
 * tile protocol assertions, bound into every cgraTile
 * store hold under back-pressure, end flag rules, freeze on stall
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module cgraAsserts (
   input logic                    clk,
   input logic                    arstN,
   input logic                    execEn,
   input logic                    stall,
   input logic                    storeReq,
   input logic                    storeGrant,
   input logic [`CGRA_DW-1:0]     storeAddr,
   input logic [`CGRA_DW-1:0]     storeData,
   input logic                    endExec,
   input cgraCtrlPkg::tileStateT  state
);

   import cgraCtrlPkg::*;

   //////////////////////////////
   // store handshake
   // ungranted request holds addr and data into the next cycle
   storeHeld: assert property (@(posedge clk) disable iff (!arstN)
      storeReq && !storeGrant |=> storeReq && $stable(storeAddr) && $stable(storeData))
      else $error("store request dropped or changed while waiting for grant");

   // a store still waiting for its grant holds off the end flag
   reqNotDone: assert property (@(posedge clk) disable iff (!arstN)
      storeReq && !storeGrant |-> ##2 !endExec)
      else $error("endExec rose right behind an ungranted store");

   //////////////////////////////
   // end flag and stall
   endAfterExecLow: assert property (@(posedge clk) disable iff (!arstN)
      $fell(endExec) |-> !$past(execEn) && state == stIdle)
      else $error("endExec fell while execEn was still high");

   frozenOnStall: assert property (@(posedge clk) disable iff (!arstN)
      stall |=> $stable(state))   // whole array holds
      else $error("tile state moved during a global stall");

endmodule

bind cgraTile cgraAsserts uAsserts (
   .clk        (clk),
   .arstN      (arstN),
   .execEn     (execEn),
   .stall      (stall),
   .storeReq   (storeReq),
   .storeGrant (storeGrant),
   .storeAddr  (storeAddr),
   .storeData  (storeData),
   .endExec    (endExec),
   .state      (state)
);

// ==== hdl/cgra.sv ====
/*
 * CGRA top level
 * torus of tiles with a shared config port, global execute enable
 * and a global stall formed from every tile's store back-pressure
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module cgra (
   input  logic                                     clk,
   input  logic                                     arstN,
   input  logic                                     cfgWrEn,
   input  logic [`CGRA_CFG_AW-1:0]                  cfgAddr,
   input  logic [`CGRA_DW-1:0]                      cfgData,
   input  logic                                     execEn,
   input  logic [`CGRA_NTILES-1:0]                  storeGrant,
   output logic [`CGRA_NTILES-1:0]                  storeReq,
   output logic [`CGRA_NTILES-1:0][`CGRA_DW-1:0]    storeAddr,
   output logic [`CGRA_NTILES-1:0][`CGRA_DW-1:0]    storeData,
   output logic [`CGRA_NTILES-1:0]                  endExec
);

   import cgraCtrlPkg::*;

   // output register of every tile, [row][col]
   logic [`CGRA_ROWS-1:0][`CGRA_COLS-1:0][`CGRA_DW-1:0] nbOut;
   logic [`CGRA_NTILES-1:0]                             stallOut;
   logic                                                stall;

   //////////////////////////////
   // global stall
   // any ungranted store freezes the whole array
   assign stall = |stallOut;

   //////////////////////////////
   // tile array
   genvar r, c;
   for (r = 0; r < `CGRA_ROWS; r++) begin : gRow
      for (c = 0; c < `CGRA_COLS; c++) begin : gCol
         localparam int tIdx = r * `CGRA_COLS + c;   // row-major

         cgraTile #(
            .tileIdx (tileIdxT'(tIdx))
         ) uTile (
            .clk        (clk),
            .arstN      (arstN),
            .cfgWrEn    (cfgWrEn),
            .cfgAddr    (cfgAddr),
            .cfgData    (cfgData),
            .execEn     (execEn),
            .stall      (stall),
            // torus links, indices wrap at the edges
            .nbN        (nbOut[(`CGRA_ROWS + r - 1) % `CGRA_ROWS][c]),
            .nbS        (nbOut[(r + 1) % `CGRA_ROWS][c]),
            .nbE        (nbOut[r][(c + 1) % `CGRA_COLS]),
            .nbW        (nbOut[r][(`CGRA_COLS + c - 1) % `CGRA_COLS]),
            .nbOut      (nbOut[r][c]),
            .storeGrant (storeGrant[tIdx]),
            .storeReq   (storeReq[tIdx]),
            .storeAddr  (storeAddr[tIdx]),
            .storeData  (storeData[tIdx]),
            .stallOut   (stallOut[tIdx]),
            .endExec    (endExec[tIdx])
         );
      end
   end

endmodule

// ==== hdl/cgraTile.sv ====
/*
 * one CGRA tile
 * run FSM, program counter, 4-entry register file, neighbour output
 * register and store port with stall back-pressure
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module cgraTile #(
   parameter cgraCtrlPkg::tileIdxT tileIdx = '0
) (
   input  logic                       clk,
   input  logic                       arstN,
   input  logic                       cfgWrEn,
   input  logic [`CGRA_CFG_AW-1:0]    cfgAddr,
   input  logic [`CGRA_DW-1:0]        cfgData,
   input  logic                       execEn,
   input  logic                       stall,      // global OR of stallOut
   input  logic [`CGRA_DW-1:0]        nbN,
   input  logic [`CGRA_DW-1:0]        nbS,
   input  logic [`CGRA_DW-1:0]        nbE,
   input  logic [`CGRA_DW-1:0]        nbW,
   output logic [`CGRA_DW-1:0]        nbOut,
   input  logic                       storeGrant,
   output logic                       storeReq,
   output logic [`CGRA_DW-1:0]        storeAddr,
   output logic [`CGRA_DW-1:0]        storeData,
   output logic                       stallOut,
   output logic                       endExec
);

   import cgraIsaPkg::*;
   import cgraCtrlPkg::*;

   tileStateT                    state;
   logic [`CGRA_PC_W-1:0]        pc;
   logic [`CGRA_PROG_DEPTH-1:0]  slotValid;   // slot written since reset
   logic [3:0][`CGRA_DW-1:0]     regs;
   logic                         storeDone;   // granted while others stall
   logic                         cfgHit;
   logic [`CGRA_DW-1:0]          memInstr;
   logic [`CGRA_DW-1:0]          instr;
   logic [`CGRA_DW-1:0]          aluResult;
   cgraOpT                       op;
   logic                         isAluOp;

   //////////////////////////////
   // configuration
   // upper address bits pick the tile
   assign cfgHit = cfgWrEn && (cfgAddr[`CGRA_CFG_AW-1 -: `CGRA_TILE_W] == tileIdx);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         slotValid <= '0;
      end else if (cfgHit) begin
         slotValid[cfgAddr[`CGRA_PC_W-1:0]] <= 1'b1;
      end
   end

   tileConfigMem uMem (
      .clk    (clk),
      .wrEn   (cfgHit),
      .wrAddr (cfgAddr[`CGRA_PC_W-1:0]),
      .wrData (cfgData),
      .pc     (pc),
      .instr  (memInstr)
   );

   // empty slot reads as NOP
   assign instr = slotValid[pc] ? memInstr : '0;

   //////////////////////////////
   // decode and datapath
   assign op      = cgraOpT'(instr[`CGRA_OP_HI:`CGRA_OP_LO]);
   assign isAluOp = (state == stRun) && (op inside {opMovi, opAdd, opSub, opAnd, opXor});

   tileAlu uAlu (
      .instr   (instr),
      .regs    (regs),
      .nbN     (nbN),
      .nbS     (nbS),
      .nbE     (nbE),
      .nbW     (nbW),
      .result  (aluResult),
      .srcAVal (storeData)
   );

   // store port, held steady by the global stall
   assign storeReq  = (state == stRun) && (op == opStore) && !storeDone;
   assign storeAddr = {{(`CGRA_DW - `CGRA_IMM_W){1'b0}}, instr[`CGRA_IMM_HI:`CGRA_IMM_LO]};
   assign stallOut  = storeReq && !storeGrant;
   assign endExec   = (state == stDone);

   //////////////////////////////
   // run FSM, pc and writeback
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state     <= stIdle;
         pc        <= '0;
         regs      <= '0;
         nbOut     <= '0;
         storeDone <= 1'b0;
      end else if (!stall) begin
         storeDone <= 1'b0;   // instruction retires this edge
         case (state)
            stIdle: begin
               if (execEn) begin
                  state <= stRun;
                  pc    <= '0;
               end
            end
            stRun: begin
               if (op == opHalt) begin
                  state <= stDone;   // pc parks on the halt
               end else begin
                  pc <= pc + 1'b1;
               end
               if (isAluOp) begin
                  regs[instr[`CGRA_DST_HI:`CGRA_DST_LO]] <= aluResult;
                  nbOut                                  <= aluResult;   // seen by all 4 nbrs
               end
            end
            stDone: begin
               if (!execEn) state <= stIdle;   // rearm for next run
            end
            default: state <= stIdle;
         endcase
      end else if (storeReq && storeGrant) begin
         storeDone <= 1'b1;   // remember grant, drop req until array moves
      end
   end

endmodule

// ==== hdl/tileAlu.sv ====
/*
 * tile operand select and arithmetic
 * picks A and B from registers or torus neighbours, computes one result
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module tileAlu (
   input  logic [`CGRA_DW-1:0]        instr,
   input  logic [3:0][`CGRA_DW-1:0]   regs,     // R0..R3
   input  logic [`CGRA_DW-1:0]        nbN,
   input  logic [`CGRA_DW-1:0]        nbS,
   input  logic [`CGRA_DW-1:0]        nbE,
   input  logic [`CGRA_DW-1:0]        nbW,
   output logic [`CGRA_DW-1:0]        result,
   output logic [`CGRA_DW-1:0]        srcAVal   // store data
);

   import cgraIsaPkg::*;

   cgraOpT               op;
   cgraSrcT              srcASel;
   cgraSrcT              srcBSel;
   logic [`CGRA_DW-1:0]  immExt;
   logic [`CGRA_DW-1:0]  opA;
   logic [`CGRA_DW-1:0]  opB;

   // operand mux, registers first then compass neighbours
   function automatic logic [`CGRA_DW-1:0] pickSrc(
      input cgraSrcT                     sel,
      input logic [3:0][`CGRA_DW-1:0]    r,
      input logic [`CGRA_DW-1:0]         n,
      input logic [`CGRA_DW-1:0]         s,
      input logic [`CGRA_DW-1:0]         e,
      input logic [`CGRA_DW-1:0]         w
   );
      case (sel)
         srcR0:   pickSrc = r[0];
         srcR1:   pickSrc = r[1];
         srcR2:   pickSrc = r[2];
         srcR3:   pickSrc = r[3];
         srcN:    pickSrc = n;
         srcS:    pickSrc = s;
         srcE:    pickSrc = e;
         srcW:    pickSrc = w;
         default: pickSrc = '0;
      endcase
   endfunction

   //////////////////////////////
   // decode
   assign op      = cgraOpT'(instr[`CGRA_OP_HI:`CGRA_OP_LO]);
   assign srcASel = cgraSrcT'(instr[`CGRA_SRCA_HI:`CGRA_SRCA_LO]);
   assign srcBSel = cgraSrcT'(instr[`CGRA_SRCB_HI:`CGRA_SRCB_LO]);
   assign immExt  = {{(`CGRA_DW - `CGRA_IMM_W){1'b0}}, instr[`CGRA_IMM_HI:`CGRA_IMM_LO]};

   assign opA     = pickSrc(srcASel, regs, nbN, nbS, nbE, nbW);
   assign opB     = pickSrc(srcBSel, regs, nbN, nbS, nbE, nbW);
   assign srcAVal = opA;

   //////////////////////////////
   // execute, wraps mod 2^DW
   always_comb begin
      case (op)
         opMovi:  result = immExt;
         opAdd:   result = opA + opB;
         opSub:   result = opA - opB;
         opAnd:   result = opA & opB;
         opXor:   result = opA ^ opB;
         default: result = '0;   // nop, store, halt write nothing
      endcase
   end

endmodule

// ==== hdl/tileConfigMem.sv ====
/*
 * tile program store
 * written from the configuration port, read combinationally at pc
 */
`timescale 1ns/100ps
`include "cgra_defs.svh"

module tileConfigMem (
   input  logic                     clk,
   input  logic                     wrEn,     // already decoded for this tile
   input  logic [`CGRA_PC_W-1:0]    wrAddr,   // slot number
   input  logic [`CGRA_DW-1:0]      wrData,
   input  logic [`CGRA_PC_W-1:0]    pc,
   output logic [`CGRA_DW-1:0]      instr
);

   //////////////////////////////
   // storage

   // one word per slot
   logic [`CGRA_DW-1:0] progMem [`CGRA_PROG_DEPTH];

   // write lands on the next edge
   always_ff @(posedge clk) begin
      if (wrEn) begin
         progMem[wrAddr] <= wrData;
      end
   end

   //////////////////////////////
   // fetch

   // async read, the tile registers nothing on this path
   // unwritten slots come back undefined, tile masks them
   assign instr = progMem[pc];

endmodule

// ==== hdl/cgraCtrlPkg.sv ====
/*
 * tile control types
 * run state and tile index
 */
`include "cgra_defs.svh"

package cgraCtrlPkg;

   //////////////////////////////
   // per-tile run state
   typedef enum logic [1:0] {
      stIdle = 2'd0,   // waiting for execEn
      stRun  = 2'd1,   // one instruction per unstalled edge
      stDone = 2'd2    // halted, endExec high until execEn drops
   } tileStateT;

   // row-major tile number, matches cfg address tile field
   typedef logic [`CGRA_TILE_W-1:0] tileIdxT;

endpackage

// ==== hdl/cgraIsaPkg.sv ====
/*
 * tile instruction set types
 * opcodes and operand source selects
 */
package cgraIsaPkg;

   //////////////////////////////
   // opcodes, 4-bit field
   // all-zero word is a NOP, so cleared slots do nothing
   typedef enum logic [3:0] {
      opNop   = 4'd0,
      opMovi  = 4'd1,   // dst = imm
      opAdd   = 4'd2,   // dst = a + b
      opSub   = 4'd3,   // dst = a - b
      opAnd   = 4'd4,
      opXor   = 4'd5,
      opStore = 4'd6,   // mem[imm] = a
      opHalt  = 4'd7    // end of program
   } cgraOpT;

   //////////////////////////////
   // operand sources, 3-bit field
   typedef enum logic [2:0] {
      srcR0 = 3'd0,
      srcR1 = 3'd1,
      srcR2 = 3'd2,
      srcR3 = 3'd3,
      srcN  = 3'd4,   // row above, wraps
      srcS  = 3'd5,   // row below, wraps
      srcE  = 3'd6,   // next column, wraps
      srcW  = 3'd7    // previous column, wraps
   } cgraSrcT;

endpackage

// ==== hdl/cgra_defs.svh ====
/*
 * CGRA global sizes and instruction word layout
 * shared by the tiles, the top level and the testbench
 */
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// array geometry, row-major tile numbering
`define CGRA_ROWS       2
`define CGRA_COLS       2
`define CGRA_NTILES     (`CGRA_ROWS * `CGRA_COLS)

`define CGRA_DW         32   // datapath and instruction width
`define CGRA_PROG_DEPTH 16   // instruction slots per tile
`define CGRA_PC_W       4    // log2 of program depth
`define CGRA_TILE_W     2    // tile select bits in cfg address
`define CGRA_CFG_AW     6    // {tile, slot}

//////////////////////////////
// instruction fields, msb first
`define CGRA_OP_HI      31
`define CGRA_OP_LO      28
`define CGRA_DST_HI     27
`define CGRA_DST_LO     26
`define CGRA_SRCA_HI    25
`define CGRA_SRCA_LO    23
`define CGRA_SRCB_HI    22
`define CGRA_SRCB_LO    20
`define CGRA_IMM_HI     15
`define CGRA_IMM_LO     0
`define CGRA_IMM_W      16   // zero-extended to CGRA_DW

`endif
